// File: Bender.yml
package:
  name: simd_alu

sources:
  - include_dirs:
      - logic
    files:
      - logic/alu_pkg.sv
      - logic/simd_adder.sv
      - logic/simd_compare.sv
      - logic/alu_bitcount.sv
      - logic/serial_divider.sv
      - logic/simd_alu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/simd_alu_assertions.sv
      - tests/simd_alu_tb.sv

// File: logic/alu_bitcount.sv
/* popcount tree and find-first-one tree with the FF1, FL1, CNT and CLB results */

`timescale 1ns/1ps

`include "alu_params.svh"

module alu_bitcount import alu_pkg::*; (
  input  alu_req_t                   req_i,
  output logic [`ALU_CNT_WIDTH-1:0]  bitop_o
);

  localparam int unsigned IDX_WIDTH = `ALU_CNT_WIDTH - 1;

  logic [`ALU_WIDTH-1:0]     op_a;
  logic [`ALU_WIDTH-1:0]     op_a_rev;
  logic [`ALU_WIDTH-1:0]     ff_in;
  logic [15:0][1:0]          pc_l1;
  logic [7:0][2:0]           pc_l2;
  logic [3:0][3:0]           pc_l3;
  logic [1:0][4:0]           pc_l4;
  logic [`ALU_CNT_WIDTH-1:0] pop_cnt;
  logic [5:0][`ALU_WIDTH-1:0]                node_sel;
  logic [5:0][`ALU_WIDTH-1:0][IDX_WIDTH-1:0] node_idx;
  logic [IDX_WIDTH-1:0]      first_idx;
  logic                      no_ones;

  assign op_a = req_i.operand_a;

  always_comb begin
    for (int k = 0; k < `ALU_WIDTH; k++) begin
      op_a_rev[k] = op_a[`ALU_WIDTH-1-k];
    end
  end

  ////////////////////
  // popcount
  ////////////////////

  // pairwise adder tree, each level one bit wider
  always_comb begin
    for (int k = 0; k < 16; k++) begin
      pc_l1[k] = {1'b0, op_a[2*k]} + {1'b0, op_a[2*k+1]};
    end
    for (int k = 0; k < 8; k++) begin
      pc_l2[k] = {1'b0, pc_l1[2*k]} + {1'b0, pc_l1[2*k+1]};
    end
    for (int k = 0; k < 4; k++) begin
      pc_l3[k] = {1'b0, pc_l2[2*k]} + {1'b0, pc_l2[2*k+1]};
    end
    for (int k = 0; k < 2; k++) begin
      pc_l4[k] = {1'b0, pc_l3[2*k]} + {1'b0, pc_l3[2*k+1]};
    end
    pop_cnt = {1'b0, pc_l4[0]} + {1'b0, pc_l4[1]};
  end

  ////////////////////
  // find first one
  ////////////////////

  // FL1 and CLB search from the top, so feed the reversed word
  always_comb begin
    unique case (req_i.operator)
      ALU_FL1: ff_in = op_a_rev;
      ALU_CLB: ff_in = op_a[`ALU_WIDTH-1] ? ~op_a_rev : op_a_rev;
      default: ff_in = op_a;
    endcase
  end

  // level 0 holds the input bits, level l has 32 >> l nodes
  // left child wins, so the lowest index is found
  always_comb begin
    node_sel = '0;
    node_idx = '0;
    for (int k = 0; k < `ALU_WIDTH; k++) begin
      node_sel[0][k] = ff_in[k];
      node_idx[0][k] = IDX_WIDTH'(k);
    end
    for (int l = 1; l <= IDX_WIDTH; l++) begin
      for (int k = 0; k < (`ALU_WIDTH >> l); k++) begin
        node_sel[l][k] = node_sel[l-1][2*k] | node_sel[l-1][2*k+1];
        node_idx[l][k] = node_sel[l-1][2*k] ? node_idx[l-1][2*k] : node_idx[l-1][2*k+1];
      end
    end
  end

  assign first_idx = node_idx[IDX_WIDTH][0];
  assign no_ones   = ~node_sel[IDX_WIDTH][0];

  ////////////////////
  // result select
  ////////////////////

  always_comb begin
    unique case (req_i.operator)
      ALU_FF1: bitop_o = no_ones ? 6'd32 : {1'b0, first_idx};
      ALU_FL1: bitop_o = no_ones ? 6'd32 : {1'b0, 5'd31 - first_idx};
      ALU_CLB: begin
        // zero gives 0, all ones has no opposite bit and gives 31
        if (no_ones) begin
          bitop_o = op_a[`ALU_WIDTH-1] ? 6'd31 : 6'd0;
        end else begin
          bitop_o = {1'b0, first_idx - 5'd1};
        end
      end
      default: bitop_o = pop_cnt;
    endcase
  end

endmodule

// File: logic/alu_params.svh
/* width and count defines shared by the packed-SIMD ALU */

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

////////////////////
// datapath widths
////////////////////

// full data word
`define ALU_WIDTH 32

// operator code
`define ALU_OP_WIDTH 5

// byte lanes in one data word
`define ALU_BYTE_LANES 4

// FF1, FL1, CNT and CLB results, 0 to 32
`define ALU_CNT_WIDTH 6

////////////////////
// divider
////////////////////

// one quotient bit per iteration
`define DIV_ITERATIONS 32

`endif

// File: logic/alu_pkg.sv
/* operator and vector-mode enums, the SIMD word union,
   the request struct and the compare-flag struct */

`include "alu_params.svh"

package alu_pkg;

  // division codes share the upper bits, bit 0 selects signed
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_AND  = 5'h00,
    ALU_OR   = 5'h01,
    ALU_XOR  = 5'h02,
    ALU_ADD  = 5'h03,
    ALU_SUB  = 5'h04,
    ALU_EQ   = 5'h05,
    ALU_NE   = 5'h06,
    ALU_LTS  = 5'h07,
    ALU_LTU  = 5'h08,
    ALU_GES  = 5'h09,
    ALU_GEU  = 5'h0a,
    ALU_MIN  = 5'h0b,
    ALU_MINU = 5'h0c,
    ALU_MAX  = 5'h0d,
    ALU_MAXU = 5'h0e,
    ALU_FF1  = 5'h0f,
    ALU_FL1  = 5'h10,
    ALU_CNT  = 5'h11,
    ALU_CLB  = 5'h12,
    ALU_DIVU = 5'h1c,
    ALU_DIV  = 5'h1d,
    ALU_REMU = 5'h1e,
    ALU_REM  = 5'h1f
  } alu_op_e;

  // lane partitioning of the data word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // one word seen as four bytes or as two halfwords
  typedef union packed {
    logic [`ALU_BYTE_LANES-1:0][7:0]    bytes;
    logic [`ALU_BYTE_LANES/2-1:0][15:0] halves;
  } simd_word_t;

  typedef struct packed {
    alu_op_e    operator;
    simd_word_t operand_a;
    simd_word_t operand_b;
    vec_mode_e  vector_mode;
  } alu_req_t;

  // per-byte masks, already merged over the active lane width
  typedef struct packed {
    logic [`ALU_BYTE_LANES-1:0] is_equal;
    logic [`ALU_BYTE_LANES-1:0] is_greater;
  } cmp_flags_t;

endpackage

// File: logic/serial_divider.sv
/* restoring serial divider for DIV, DIVU, REM and REMU with the ready/stall handshake */

`timescale 1ns/1ps

`include "alu_params.svh"

module serial_divider import alu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  alu_req_t               req_i,
  input  logic                   ex_ready_i,
  output logic [`ALU_WIDTH-1:0]  div_result_o,
  output logic                   div_ready_o
);

  localparam int unsigned          ITER_W    = $clog2(`DIV_ITERATIONS);
  localparam logic [ITER_W-1:0]    LAST_ITER = ITER_W'(`DIV_ITERATIONS - 1);
  localparam logic [`ALU_WIDTH-1:0] MOST_NEG = {1'b1, {(`ALU_WIDTH-1){1'b0}}};

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

  div_state_e            state_q;
  logic [ITER_W-1:0]     iter_q;
  logic                  is_div_op;
  logic                  is_rem;
  logic                  is_signed;
  logic                  a_neg;
  logic                  b_neg;
  logic [`ALU_WIDTH-1:0] op_a;
  logic [`ALU_WIDTH-1:0] op_b;
  logic                  load;
  // payload
  logic [`ALU_WIDTH-1:0] divisor_q;
  logic [`ALU_WIDTH-1:0] rem_q;
  logic [`ALU_WIDTH-1:0] quot_q;
  logic                  q_neg_q;
  logic                  r_neg_q;
  logic                  by_zero_q;
  logic                  overflow_q;
  // one restoring step
  logic [`ALU_WIDTH:0]   trial;
  logic [`ALU_WIDTH:0]   diff;
  logic                  fits;
  // done stage
  logic [`ALU_WIDTH-1:0] quotient;
  logic [`ALU_WIDTH-1:0] remainder;

  assign op_a      = req_i.operand_a;
  assign op_b      = req_i.operand_b;
  assign is_div_op = req_i.operator inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  assign is_rem    = req_i.operator inside {ALU_REM, ALU_REMU};
  // lowest operator bit marks the signed forms
  assign is_signed = req_i.operator[0];
  assign a_neg     = is_signed & op_a[`ALU_WIDTH-1];
  assign b_neg     = is_signed & op_b[`ALU_WIDTH-1];
  assign load      = (state_q == DIV_IDLE) && is_div_op;

  ////////////////////
  // control FSM
  ////////////////////

  // load edge, then DIV_ITERATIONS step edges, the last one enters DONE
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= DIV_IDLE;
      iter_q  <= '0;
    end else begin
      unique case (state_q)
        DIV_IDLE: begin
          if (is_div_op) begin
            state_q <= DIV_BUSY;
            iter_q  <= '0;
          end
        end
        DIV_BUSY: begin
          iter_q <= iter_q + 1'b1;
          if (iter_q == LAST_ITER) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          // hold the result until the pipeline takes it
          if (ex_ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  ////////////////////
  // datapath
  ////////////////////

  // shift in the next dividend bit and try the subtract
  assign trial = {rem_q, quot_q[`ALU_WIDTH-1]};
  assign diff  = trial - {1'b0, divisor_q};
  assign fits  = (trial >= {1'b0, divisor_q});

  always_ff @(posedge clk) begin
    if (load) begin
      // magnitudes, dividend enters the quotient register
      quot_q     <= a_neg ? -op_a : op_a;
      divisor_q  <= b_neg ? -op_b : op_b;
      rem_q      <= '0;
      q_neg_q    <= a_neg ^ b_neg;
      r_neg_q    <= a_neg;
      by_zero_q  <= (op_b == '0);
      overflow_q <= is_signed && (op_a == MOST_NEG) && (op_b == '1);
    end else if (state_q == DIV_BUSY) begin
      rem_q  <= fits ? diff[`ALU_WIDTH-1:0] : trial[`ALU_WIDTH-1:0];
      quot_q <= {quot_q[`ALU_WIDTH-2:0], fits};
    end
  end

  // sign correction, remainder follows the dividend
  // a zero divisor leaves the dividend magnitude in rem_q
  always_comb begin
    remainder = r_neg_q ? -rem_q : rem_q;
    quotient  = q_neg_q ? -quot_q : quot_q;
    if (by_zero_q) begin
      quotient = '1;
    end else if (overflow_q) begin
      quotient  = MOST_NEG;
      remainder = '0;
    end
  end

  assign div_result_o = is_rem ? remainder : quotient;

  // non-division operators never stall
  assign div_ready_o = ~is_div_op | (state_q == DIV_DONE);

endmodule

// File: logic/simd_adder.sv
/* partitioned add/subtract over one, two or four lanes */

`timescale 1ns/1ps

`include "alu_params.svh"

module simd_adder import alu_pkg::*; (
  input  alu_req_t               req_i,
  output logic [`ALU_WIDTH-1:0]  sum_o
);

  localparam int unsigned EXT_WIDTH = `ALU_WIDTH + `ALU_BYTE_LANES;

  logic                       do_sub;
  logic [`ALU_BYTE_LANES-1:0] lane_start;
  logic [EXT_WIDTH-1:0]       ext_a;
  logic [EXT_WIDTH-1:0]       ext_b;
  logic [EXT_WIDTH-1:0]       ext_sum;

  assign do_sub = (req_i.operator == ALU_SUB);

  // bytes that begin a new lane
  always_comb begin
    unique case (req_i.vector_mode)
      VEC_MODE8:  lane_start = 4'b1111;
      VEC_MODE16: lane_start = 4'b0101;
      default:    lane_start = 4'b0001;
    endcase
  end

  ////////////////////
  // extended operands
  ////////////////////

  // one control bit sits below every byte
  // lane start, add    0 + 0 kills the carry from below
  // lane start, sub    1 + 1 injects the +1 of the two's complement
  // inside a lane      1 + 0 passes the carry through
  always_comb begin
    for (int i = 0; i < `ALU_BYTE_LANES; i++) begin
      ext_a[9*i+1 +: 8] = req_i.operand_a.bytes[i];
      ext_b[9*i+1 +: 8] = do_sub ? ~req_i.operand_b.bytes[i] : req_i.operand_b.bytes[i];
      ext_a[9*i]        = do_sub | ~lane_start[i];
      ext_b[9*i]        = do_sub & lane_start[i];
    end
  end

  // single wide adder for all lanes
  assign ext_sum = ext_a + ext_b;

  // drop the control bits again
  always_comb begin
    for (int i = 0; i < `ALU_BYTE_LANES; i++) begin
      sum_o[8*i +: 8] = ext_sum[9*i+1 +: 8];
    end
  end

endmodule

// File: logic/simd_alu.sv
/* packed-SIMD ALU top with logic operations, sub-unit instances and result mux */

`timescale 1ns/1ps

`include "alu_params.svh"

module simd_alu import alu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  alu_req_t               alu_req_i,
  input  logic                   ex_ready_i,
  output logic [`ALU_WIDTH-1:0]  result_o,
  output logic                   comparison_result_o,
  output logic                   ready_o
);

  logic [`ALU_WIDTH-1:0]     adder_sum;
  logic                      cmp_result;
  logic [`ALU_WIDTH-1:0]     minmax_result;
  logic [`ALU_CNT_WIDTH-1:0] bitop_result;
  logic [`ALU_WIDTH-1:0]     div_result;
  logic                      div_ready;

  ////////////////////
  // sub-units
  ////////////////////

  simd_adder u_adder (
    .req_i ( alu_req_i ),
    .sum_o ( adder_sum )
  );

  // lane masks stay internal, only the flag and min/max leave
  simd_compare u_compare (
    .req_i        ( alu_req_i     ),
    .cmp_flags_o  (               ),
    .cmp_result_o ( cmp_result    ),
    .minmax_o     ( minmax_result )
  );

  alu_bitcount u_bitcount (
    .req_i   ( alu_req_i    ),
    .bitop_o ( bitop_result )
  );

  // multi-cycle, stalls the pipeline through ready_o
  serial_divider u_divider (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n_i    ),
    .req_i        ( alu_req_i  ),
    .ex_ready_i   ( ex_ready_i ),
    .div_result_o ( div_result ),
    .div_ready_o  ( div_ready  )
  );

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    unique case (alu_req_i.operator)
      ALU_AND: result_o = alu_req_i.operand_a & alu_req_i.operand_b;
      ALU_OR:  result_o = alu_req_i.operand_a | alu_req_i.operand_b;
      ALU_XOR: result_o = alu_req_i.operand_a ^ alu_req_i.operand_b;

      ALU_ADD, ALU_SUB: result_o = adder_sum;

      // flag of the top lane, zero-extended
      ALU_EQ,  ALU_NE,
      ALU_LTS, ALU_LTU,
      ALU_GES, ALU_GEU: result_o = {{(`ALU_WIDTH-1){1'b0}}, cmp_result};

      ALU_MIN, ALU_MINU,
      ALU_MAX, ALU_MAXU: result_o = minmax_result;

      ALU_FF1, ALU_FL1,
      ALU_CNT, ALU_CLB: result_o = {{(`ALU_WIDTH-`ALU_CNT_WIDTH){1'b0}}, bitop_result};

      ALU_DIV, ALU_DIVU,
      ALU_REM, ALU_REMU: result_o = div_result;

      default: result_o = '0;
    endcase
  end

  assign comparison_result_o = cmp_result;
  assign ready_o             = div_ready;

endmodule

// File: logic/simd_compare.sv
/* lane-aware compare flags, comparison result and min/max selection */

`timescale 1ns/1ps

`include "alu_params.svh"

module simd_compare import alu_pkg::*; (
  input  alu_req_t               req_i,
  output cmp_flags_t             cmp_flags_o,
  output logic                   cmp_result_o,
  output logic [`ALU_WIDTH-1:0]  minmax_o
);

  logic                       op_signed;
  logic                       do_min;
  logic [`ALU_BYTE_LANES-1:0] cmp_signed;
  logic [`ALU_BYTE_LANES-1:0] eq_byte;
  logic [`ALU_BYTE_LANES-1:0] gt_byte;
  logic [1:0]                 eq_half;
  logic                       eq_word;
  cmp_flags_t                 flags;
  logic [`ALU_BYTE_LANES-1:0] lane_flag;
  logic [`ALU_BYTE_LANES-1:0] sel_a;

  assign op_signed = req_i.operator inside {ALU_LTS, ALU_GES, ALU_MIN, ALU_MAX};
  assign do_min    = req_i.operator inside {ALU_MIN, ALU_MINU};

  // only the top byte of a lane carries the sign
  always_comb begin
    unique case (req_i.vector_mode)
      VEC_MODE8:  cmp_signed = {4{op_signed}};
      VEC_MODE16: cmp_signed = {op_signed, 1'b0, op_signed, 1'b0};
      default:    cmp_signed = {op_signed, 3'b000};
    endcase
  end

  ////////////////////
  // byte compares
  ////////////////////

  always_comb begin
    for (int i = 0; i < `ALU_BYTE_LANES; i++) begin
      eq_byte[i] = (req_i.operand_a.bytes[i] == req_i.operand_b.bytes[i]);
      gt_byte[i] = $signed({req_i.operand_a.bytes[i][7] & cmp_signed[i],
                            req_i.operand_a.bytes[i]}) >
                   $signed({req_i.operand_b.bytes[i][7] & cmp_signed[i],
                            req_i.operand_b.bytes[i]});
    end
  end

  // equality of wider lanes straight from the halfword view
  assign eq_half[0] = (req_i.operand_a.halves[0] == req_i.operand_b.halves[0]);
  assign eq_half[1] = (req_i.operand_a.halves[1] == req_i.operand_b.halves[1]);
  assign eq_word    = &eq_half;

  ////////////////////
  // lane merge
  ////////////////////

  // greater is decided by the highest byte that differs
  always_comb begin
    unique case (req_i.vector_mode)
      VEC_MODE8: begin
        flags.is_equal   = eq_byte;
        flags.is_greater = gt_byte;
      end
      VEC_MODE16: begin
        flags.is_equal   = {{2{eq_half[1]}}, {2{eq_half[0]}}};
        flags.is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                            {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      default: begin
        flags.is_equal   = {4{eq_word}};
        flags.is_greater = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                             (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  assign cmp_flags_o = flags;

  // operator decode into the per-lane flag
  always_comb begin
    unique case (req_i.operator)
      ALU_NE:           lane_flag = ~flags.is_equal;
      ALU_LTS, ALU_LTU: lane_flag = ~(flags.is_greater | flags.is_equal);
      ALU_GES, ALU_GEU: lane_flag = flags.is_greater | flags.is_equal;
      default:          lane_flag = flags.is_equal;
    endcase
  end

  // most significant lane drives the scalar flag
  assign cmp_result_o = lane_flag[`ALU_BYTE_LANES-1];

  // min takes b where a is greater, max takes a
  assign sel_a = flags.is_greater ^ {`ALU_BYTE_LANES{do_min}};

  always_comb begin
    for (int i = 0; i < `ALU_BYTE_LANES; i++) begin
      minmax_o[8*i +: 8] = sel_a[i] ? req_i.operand_a.bytes[i] : req_i.operand_b.bytes[i];
    end
  end

endmodule

// File: project.f
+incdir+logic
logic/alu_pkg.sv
logic/simd_adder.sv
logic/simd_compare.sv
logic/alu_bitcount.sv
logic/serial_divider.sv
logic/simd_alu.sv
tests/simd_alu_assertions.sv
tests/simd_alu_tb.sv

// File: tests/simd_alu_assertions.sv
/* bound concurrent checks on ready_o and the held division result */

`timescale 1ns/1ps

`include "alu_params.svh"

module simd_alu_assertions import alu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  alu_req_t               alu_req_i,
  input  logic                   ex_ready_i,
  input  logic [`ALU_WIDTH-1:0]  result_i,
  input  logic                   ready_i
);

  // read by the testbench
  int   assert_errors = 0;
  logic div_op;

  assign div_op = alu_req_i.operator inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

  // combinational operators never stall
  ready_non_div: assert property (@(posedge clk) disable iff (!rst_n_i)
    !div_op |-> ready_i)
  else begin
    $error("ready_o low for a non-division operator");
    assert_errors++;
  end

  // back-pressure holds result and ready
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    (div_op && ready_i && !ex_ready_i) |=> ($stable(result_i) && ready_i))
  else begin
    $error("division result or ready_o changed under back-pressure");
    assert_errors++;
  end

  ready_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown(ready_i))
  else begin
    $error("ready_o is unknown");
    assert_errors++;
  end

endmodule

bind simd_alu simd_alu_assertions u_assertions (
  .clk        ( clk        ),
  .rst_n_i    ( rst_n_i    ),
  .alu_req_i  ( alu_req_i  ),
  .ex_ready_i ( ex_ready_i ),
  .result_i   ( result_o   ),
  .ready_i    ( ready_o    )
);

// File: tests/simd_alu_tb.sv
/* testbench for the packed-SIMD ALU: clock, reset, stimulus,
   reference model, compare process and timeout */

`timescale 1ns/1ps

`include "alu_params.svh"

module simd_alu_tb import alu_pkg::*; ();

  localparam logic [31:0] SEED         = 32'hb30d_31ff;
  localparam int          RESET_CYCLES = 5;
  // one division is 34 cycles without stall, budget a bit more
  localparam int          DIV_BUDGET   = 40;
  localparam int          MAX_STALL    = 6;
  localparam int          N_LANE_RAND  = 5;
  localparam int          N_BASIC      = 40 + 2;
  localparam int          N_LANE_ADD   = 2 * 2 * (3 + N_LANE_RAND);
  localparam int          N_COMPARE    = 6 * 3 * (3 + 2 + 1);
  localparam int          N_MINMAX     = 4 * 3 * (2 + 2 + 1);
  localparam int          N_BITCOUNT   = 4 * (7 + 6);
  localparam int          N_DIVS       = 4 * 5;
  localparam int          N_NONDIV     = N_BASIC + N_LANE_ADD + N_COMPARE + N_MINMAX + N_BITCOUNT;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + N_NONDIV + N_DIVS * DIV_BUDGET +
                                           MAX_STALL + 100;

  logic                  clk;
  logic                  rst_n_i;
  alu_req_t              alu_req_i;
  logic                  ex_ready_i;
  logic [`ALU_WIDTH-1:0] result_o;
  logic                  comparison_result_o;
  logic                  ready_o;

  logic                  checking;
  string                 test_name;
  int                    cycle_count;
  logic [`ALU_WIDTH-1:0] exp_word;
  logic                  exp_flag;

  // operand and operator lists for the sweeps
  alu_op_e               ops_q[$];
  vec_mode_e             modes_q[$];
  logic [31:0]           a_q[$];
  logic [31:0]           b_q[$];
  alu_op_e               basic_ops[5] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB};
  alu_op_e               div_ops[4]   = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  vec_mode_e             all_modes[3] = '{VEC_MODE32, VEC_MODE16, VEC_MODE8};

  simd_alu DUT (
    .clk                 ( clk                 ),
    .rst_n_i             ( rst_n_i             ),
    .alu_req_i           ( alu_req_i           ),
    .ex_ready_i          ( ex_ready_i          ),
    .result_o            ( result_o            ),
    .comparison_result_o ( comparison_result_o ),
    .ready_o             ( ready_o             )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////

  // lane value, sign-extended when the operator is signed
  function automatic longint lane_val(input logic [63:0] u, input int w, input logic sgn);
    if (sgn && u[w-1]) begin
      return longint'(u) - longint'(64'd1 << w);
    end
    return longint'(u);
  endfunction

  function automatic void ref_alu(input alu_req_t req, output logic [`ALU_WIDTH-1:0] word,
                                  output logic flag);
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    int                 w;
    int                 n;
    logic [63:0]        mask;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        acc;
    longint             va;
    longint             vb;
    logic               sgn;
    logic               ovf;
    a    = req.operand_a;
    b    = req.operand_b;
    sa   = a;
    sb   = b;
    word = '0;
    flag = 1'b0;
    acc  = '0;
    w    = (req.vector_mode == VEC_MODE16) ? 16 : (req.vector_mode == VEC_MODE8) ? 8 : 32;
    mask = (64'd1 << w) - 1;
    sgn  = req.operator inside {ALU_LTS, ALU_GES, ALU_MIN, ALU_MAX};
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (req.operator)
      ALU_AND: word = a & b;
      ALU_OR:  word = a | b;
      ALU_XOR: word = a ^ b;
      // lowest set bit wins, so scan downward
      ALU_FF1: begin
        word = 32;
        for (int k = 31; k >= 0; k--) if (a[k]) word = k;
      end
      ALU_FL1: begin
        word = 32;
        for (int k = 0; k < 32; k++) if (a[k]) word = k;
      end
      ALU_CNT: for (int k = 0; k < 32; k++) word = word + a[k];
      ALU_CLB: begin
        n = 0;
        for (int k = 31; k >= 0 && a[k] == a[31]; k--) n++;
        word = (a == '0) ? 0 : n - 1;
      end
      ALU_DIVU: word = (b == '0) ? '1 : a / b;
      ALU_REMU: word = (b == '0) ? a : a % b;
      // signed forms on signed locals, truncation toward zero
      ALU_DIV: begin
        if (b == '0) begin
          word = '1;
        end else if (ovf) begin
          word = a;
        end else begin
          word = sa / sb;
        end
      end
      ALU_REM: begin
        if (b == '0) begin
          word = a;
        end else if (ovf) begin
          word = '0;
        end else begin
          word = sa % sb;
        end
      end
      default: begin
        // add/sub, compares and min/max lane by lane
        for (int l = 0; l < 32 / w; l++) begin
          ua = (a >> (l * w)) & mask;
          ub = (b >> (l * w)) & mask;
          va = lane_val(ua, w, sgn);
          vb = lane_val(ub, w, sgn);
          case (req.operator)
            ALU_ADD:            acc = acc | (((ua + ub) & mask) << (l * w));
            ALU_SUB:            acc = acc | (((ua - ub) & mask) << (l * w));
            ALU_EQ:             flag = (va == vb);
            ALU_NE:             flag = (va != vb);
            ALU_LTS, ALU_LTU:   flag = (va < vb);
            ALU_GES, ALU_GEU:   flag = (va >= vb);
            ALU_MIN, ALU_MINU:  acc = acc | (((va < vb) ? ua : ub) << (l * w));
            ALU_MAX, ALU_MAXU:  acc = acc | (((va > vb) ? ua : ub) << (l * w));
            default:            acc = acc;
          endcase
        end
        // last lane visited is the top lane
        word = is_compare(req.operator) ? {31'b0, flag} : acc[31:0];
      end
    endcase
  endfunction

  function automatic logic is_compare(input alu_op_e op);
    return op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
  endfunction

  function automatic logic is_division(input alu_op_e op);
    return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [`ALU_WIDTH-1:0] expected,
                            input logic [`ALU_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  // inputs change on falling edges, so rising edges see settled outputs
  always @(posedge clk) begin
    if (rst_n_i && checking) begin
      ref_alu(alu_req_i, exp_word, exp_flag);
      if (!is_division(alu_req_i.operator)) begin
        check_word(test_name, exp_word, result_o);
        if (is_compare(alu_req_i.operator)) begin
          check_flag({test_name, " flag"}, exp_flag, comparison_result_o);
        end
      end else if (ready_o) begin
        check_word(test_name, exp_word, result_o);
      end
      if (DUT.u_assertions.assert_errors != 0) begin
        $display("a bound assertion on the DUT failed");
        abort_run();
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_request(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                               input vec_mode_e mode);
    alu_req_i.operator    = op;
    alu_req_i.operand_a   = a;
    alu_req_i.operand_b   = b;
    alu_req_i.vector_mode = mode;
    @(negedge clk);
  endtask

  // every operator in every mode, directed pairs then random ones
  task automatic sweep(input int n_rand, input int n_equal);
    logic [31:0] r;
    foreach (ops_q[i]) begin
      foreach (modes_q[j]) begin
        foreach (a_q[k]) drive_request(ops_q[i], a_q[k], b_q[k], modes_q[j]);
        repeat (n_rand) drive_request(ops_q[i], $urandom, $urandom, modes_q[j]);
        repeat (n_equal) begin
          r = $urandom;
          drive_request(ops_q[i], r, r, modes_q[j]);
        end
      end
    end
  endtask

  // load edge is the first rising edge after the request is driven
  task automatic run_division(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                              input int stall);
    int                    edges;
    logic [`ALU_WIDTH-1:0] held;
    alu_req_i.operator    = op;
    alu_req_i.operand_a   = a;
    alu_req_i.operand_b   = b;
    alu_req_i.vector_mode = all_modes[$urandom % 3];
    ex_ready_i            = (stall == 0);
    edges                 = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ready_o && edges < DIV_BUDGET);
    check_word("division latency", `DIV_ITERATIONS + 1, 32'(edges));
    held = result_o;
    // back-pressure, result must hold
    repeat (stall) begin
      @(posedge clk);
      @(negedge clk);
      check_flag("ready during stall", 1'b1, ready_o);
      check_word("result during stall", held, result_o);
    end
    ex_ready_i = 1'b1;
    // this edge returns the divider to idle
    @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    alu_req_i   = '0;
    ex_ready_i  = 1'b1;
    checking    = 1'b0;
    cycle_count = 0;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i  = 1'b1;
    checking = 1'b1;

    test_name = "logic and 32-bit add/sub";
    repeat (N_BASIC - 2) drive_request(basic_ops[$urandom % 5], $urandom, $urandom, VEC_MODE32);
    drive_request(ALU_ADD, 32'hffff_ffff, 32'h0000_0001, VEC_MODE32);
    drive_request(ALU_SUB, 32'h0000_0000, 32'h0000_0001, VEC_MODE32);

    // lane overflow must not cross lane boundaries
    test_name = "lane add/sub";
    ops_q     = {ALU_ADD, ALU_SUB};
    modes_q   = {VEC_MODE16, VEC_MODE8};
    a_q       = {32'hffff_ffff, 32'h0000_0000, 32'h8080_8080};
    b_q       = {32'h0101_0101, 32'h0101_0101, 32'h8080_8080};
    sweep(N_LANE_RAND, 0);

    test_name = "compare";
    ops_q     = {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
    modes_q   = {VEC_MODE32, VEC_MODE16, VEC_MODE8};
    a_q       = {32'h8080_8080, 32'h7f7f_7f7f, 32'h00ff_00ff};
    b_q       = {32'h7f7f_7f7f, 32'h8080_8080, 32'hff00_ff00};
    sweep(2, 1);

    test_name = "min/max";
    ops_q     = {ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU};
    a_q       = {32'h807f_01ff, 32'hffff_0001};
    b_q       = {32'h7f80_ff01, 32'h0001_ffff};
    sweep(2, 1);

    // single-bit words included
    test_name = "bit count";
    ops_q     = {ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB};
    modes_q   = {VEC_MODE32};
    a_q       = {32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h1, 32'h20, 32'h1_0000, 32'h4000_0000};
    b_q       = {32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    sweep(6, 0);

    test_name = "division";
    foreach (div_ops[i]) begin
      run_division(div_ops[i], $urandom, $urandom, 0);
      run_division(div_ops[i], -(32'($urandom % 100000) + 1), 32'($urandom % 97) + 2, MAX_STALL);
      run_division(div_ops[i], $urandom, 32'hffff_fff9, 0);
      run_division(div_ops[i], $urandom, 32'h0, 0);
      run_division(div_ops[i], 32'h8000_0000, 32'hffff_ffff, 0);
    end

    checking = 1'b0;
    if (DUT.u_assertions.assert_errors == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("a bound assertion on the DUT failed");
      abort_run();
    end
  end

endmodule
